// ==== all.f ====
+incdir+common
common/lsf_pkg.sv
source/basic_op_unit.sv
source/l_shl_unit.sv
source/lsf_ram.sv
source/lsf_host_port.sv
lsp_lsf/lsp_lsf.sv
source/lsf_top.sv
tests/lsf_chk.sv
tests/lsf_tb.sv

// ==== tests/lsf_trace.txt ====
# cosine table (64), slope table (64), run count, then per run:
# output base, ten input coefficients 0..9, ten expected results 0..9 (all hex)
4000 3E00 3C00 3A00 3800 3600 3400 3200
3000 2E00 2C00 2A00 2800 2600 2400 2200
2000 1E00 1C00 1A00 1800 1600 1400 1200
1000 0E00 0C00 0A00 0800 0600 0400 0200
0000 FE00 FC00 FA00 F800 F600 F400 F200
F000 EE00 EC00 EA00 E800 E600 E400 E200
E000 DE00 DC00 DA00 D800 D600 D400 D200
D000 CE00 CC00 CA00 C800 C600 C400 C200
F800 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 8000
3
100
4000 36B0 270F 15B3 03E8 0000 F447 E0C0 D120 8000
0000 04A8 0C79 1527 1E0C 2000 25DD 2FA0 3770 7FFF
200
3E80 32C9 2904 1B58 1001 07D0 FF9C EC78 D8F0 C568
00C0 069C 0B7E 1254 1800 1C18 2032 29C4 3388 3D4C
300
4000 36B0 270F 15B3 03E8 0000 F447 E0C0 D120 8000
0000 04A8 0C79 1527 1E0C 2000 25DD 2FA0 3770 7FFF

// ==== tests/lsf_tb.sv ====
`timescale 1ns/1ps
`include "lsf_defs.svh"

module lsf_tb;

	localparam int max_runs = 3;
	localparam int ack_limit = 4000;
	localparam int poll_limit = 3000;

	logic clock;
	logic reset;
	lsf_pkg::wb_req_t wb_req;
	lsf_pkg::wb_rsp_t wb_rsp;

	logic [31:0] cos_tab [64];
	logic [31:0] slope_tab [64];
	logic [10:0] run_base [max_runs];
	logic [31:0] run_lsp [max_runs][10];
	logic [31:0] run_exp [max_runs][10];
	int n_runs;
	int fd;
	int errors;
	int checks;
	logic [31:0] rng;
	logic trace_ready;

	lsf_top dut_i (
		.clock(clock),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	always #4 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [13:0] scratch_adr(input logic [10:0] a);
		return {`LSF_RGN_SCRATCH, 1'b0, a};
	endfunction

	function automatic logic [13:0] const_adr(input logic [11:0] a);
		return {`LSF_RGN_CONST, a};
	endfunction

	function automatic logic [13:0] reg_adr(input logic off);
		return {`LSF_RGN_REGS, 11'd0, off};
	endfunction

	// Marks result words that no run has written yet
	function automatic logic [31:0] fill_word(input logic [10:0] a);
		return {5'h15, a, 5'h0a, a};
	endfunction

	task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// One classic cycle, random idle gap in front
	task automatic bus_access(input logic we, input logic [13:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat, output int waited);
		int gap;
		bit got;
		rng = xorshift(rng);
		gap = 1 + int'(rng[1:0]);
		repeat (gap) @(posedge clock);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		waited = 0;
		got = 0;
		rdat = '0;
		while (!got && waited < ack_limit) begin
			@(negedge clock);
			if (wb_rsp.ack) begin
				got = 1;
				rdat = wb_rsp.dat;
			end else begin
				waited++;
			end
		end
		if (!got) begin
			$display("ERROR: no ack for bus access at address %h", adr);
			errors++;
		end
		@(posedge clock);
		#1;
		wb_req = '0;
	endtask

	task automatic bus_write(input logic [13:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		int waited;
		bus_access(1'b1, adr, dat, unused, waited);
	endtask

	task automatic bus_read(input logic [13:0] adr, output logic [31:0] dat);
		int waited;
		bus_access(1'b0, adr, 32'd0, dat, waited);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Trace and test steps
	//////////////////////////////////////////////////////////////////////

	task automatic load_trace();
		string line;
		int code;
		int bad;
		logic [31:0] v;
		bad = 0;
		code = $fgets(line, fd);
		bad += (code == 0);
		code = $fgets(line, fd);
		bad += (code == 0);
		for (int i = 0; i < 64; i++)
			bad += ($fscanf(fd, "%h", cos_tab[i]) != 1);
		for (int i = 0; i < 64; i++)
			bad += ($fscanf(fd, "%h", slope_tab[i]) != 1);
		bad += ($fscanf(fd, "%h", v) != 1);
		n_runs = int'(v);
		for (int r = 0; r < max_runs; r++) begin
			bad += ($fscanf(fd, "%h", v) != 1);
			run_base[r] = v[10:0];
			for (int i = 0; i < 10; i++)
				bad += ($fscanf(fd, "%h", run_lsp[r][i]) != 1);
			for (int i = 0; i < 10; i++)
				bad += ($fscanf(fd, "%h", run_exp[r][i]) != 1);
		end
		if (bad != 0) begin
			$display("ERROR: trace file ended early or holds bad values");
			errors++;
		end
		$fclose(fd);
	endtask

	task automatic write_inputs(input int r);
		logic [31:0] d;
		for (int i = 0; i < `LSF_ORDER; i++)
			bus_write(scratch_adr(11'(`LSF_LSP_BASE + i)), run_lsp[r][i]);
		for (int i = 0; i < `LSF_ORDER; i++) begin
			bus_read(scratch_adr(11'(`LSF_LSP_BASE + i)), d);
			check_equal($sformatf("run %0d input %0d", r, i), run_lsp[r][i], d);
		end
	endtask

	task automatic launch_run(input int r);
		bus_write(reg_adr(1'b0), {5'd0, run_base[r], 15'd0, 1'b1});
	endtask

	// Poll status until the sticky done shows up
	task automatic wait_run_done(input int r);
		logic [31:0] st;
		int polls;
		polls = 0;
		st = '0;
		while (!st[1] && polls < poll_limit) begin
			bus_read(reg_adr(1'b1), st);
			polls++;
		end
		if (!st[1]) begin
			$display("ERROR: run %0d never reported done in status", r);
			errors++;
		end
		check_equal($sformatf("run %0d status", r), 32'd2, st);
	endtask

	task automatic check_results(input int r, input string tag);
		logic [31:0] d;
		for (int i = 0; i < `LSF_ORDER; i++) begin
			bus_read(scratch_adr(11'(run_base[r] + i)), d);
			check_equal($sformatf("%s result %0d", tag, i), run_exp[r][i], d);
		end
	endtask

	task automatic check_untouched(input logic [10:0] base, input string tag);
		logic [31:0] d;
		for (int i = 0; i < `LSF_ORDER; i++) begin
			bus_read(scratch_adr(11'(base + i)), d);
			check_equal($sformatf("%s word %0d", tag, i), fill_word(11'(base + i)), d);
		end
	endtask

	task automatic run_behaviors();
		logic [31:0] d;
		int waited;
		// Reset state and first access
		bus_read(reg_adr(1'b1), d);
		check_equal("status after reset", 32'd0, d);

		for (int i = 0; i < 64; i++) begin
			bus_write(const_adr(12'(`LSF_TABLE_BASE + i)), cos_tab[i]);
			bus_write(const_adr(12'(`LSF_SLOPE_BASE + i)), slope_tab[i]);
		end
		for (int i = 0; i < 64; i++) begin
			bus_read(const_adr(12'(`LSF_TABLE_BASE + i)), d);
			check_equal($sformatf("cosine %0d", i), cos_tab[i], d);
			bus_read(const_adr(12'(`LSF_SLOPE_BASE + i)), d);
			check_equal($sformatf("slope %0d", i), slope_tab[i], d);
		end
		for (int r = 0; r < max_runs; r++)
			for (int i = 0; i < `LSF_ORDER; i++)
				bus_write(scratch_adr(11'(run_base[r] + i)), fill_word(11'(run_base[r] + i)));

		write_inputs(0);
		launch_run(0);
		wait_run_done(0);
		check_results(0, "run 0");

		write_inputs(1);
		launch_run(1);
		wait_run_done(1);
		check_results(1, "run 1");
		check_results(0, "run 0 after run 1");
		check_untouched(run_base[2], "unused region");

		// Scratch write held off until the engine lets go
		write_inputs(2);
		launch_run(2);
		bus_access(1'b1, scratch_adr(11'h7f0), 32'ha5a5_1234, d, waited);
		if (waited < 10) begin
			$display("ERROR: scratch write acknowledged after %0d cycles while busy", waited);
			errors++;
		end
		bus_read(reg_adr(1'b1), d);
		check_equal("status after held write", 32'd2, d);
		bus_read(scratch_adr(11'h7f0), d);
		check_equal("held write data", 32'ha5a5_1234, d);
		check_results(2, "run 2");
		check_results(0, "run 0 after run 2");
		check_results(1, "run 1 after run 2");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main flow and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		wb_req = '0;
		errors = 0;
		checks = 0;
		n_runs = 0;
		rng = 32'hfd70;
		trace_ready = 1'b0;
		fd = $fopen("tests/lsf_trace.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open trace file tests/lsf_trace.txt");
			$display("CHECKS FAILED");
			$finish;
		end else begin
			load_trace();
			trace_ready = 1'b1;
			repeat (2) @(posedge clock);
			#1;
			reset = 1'b0;
			if (n_runs != max_runs) begin
				$display("ERROR: trace holds %0d runs instead of %0d", n_runs, max_runs);
				errors++;
			end else begin
				run_behaviors();
			end
			$display("checks: %0d errors: %0d", checks, errors);
			if (errors == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
			$finish;
		end
	end

	// Search bound per run plus loading and polling margin
	initial begin
		wait (trace_ready);
		repeat (n_runs * 64 * 12 + 6000) @(posedge clock);
		$display("ERROR: watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== tests/lsf_chk.sv ====
`timescale 1ns/1ps
`include "lsf_defs.svh"

module lsf_chk (
	input logic clock,
	input logic reset,
	input lsf_pkg::wb_req_t wb_req,
	input lsf_pkg::wb_rsp_t wb_rsp,
	input logic busy,
	input logic [1:0] rgn_q,
	input logic shift_start,
	input logic shift_done
);

	// Classic cycle ends after a single ack
	ack_one_cycle: assert property (@(posedge clock) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("ack held for more than one cycle");

	ack_needs_stb: assert property (@(posedge clock) disable iff (reset)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
		else $error("ack without an active strobe");

	// Engine owns the RAMs while busy
	no_mem_ack_busy: assert property (@(posedge clock) disable iff (reset)
		(wb_rsp.ack && rgn_q != `LSF_RGN_REGS) |-> !busy)
		else $error("memory access acknowledged while busy");

	shift_done_hold: assert property (@(posedge clock) disable iff (reset)
		$fell(shift_done) |-> $past(shift_start))
		else $error("shifter done dropped without a start");

endmodule

bind lsf_top lsf_chk chk_i (
	.clock(clock),
	.reset(reset),
	.wb_req(wb_req),
	.wb_rsp(wb_rsp),
	.busy(host_port_i.busy),
	.rgn_q(host_port_i.rgn_q),
	.shift_start(shift_start),
	.shift_done(shift_done)
);

// ==== source/lsf_top.sv ====
`timescale 1ns/1ps
`include "lsf_defs.svh"

module lsf_top (
	input logic clock,
	input logic reset,
	input lsf_pkg::wb_req_t wb_req,
	output lsf_pkg::wb_rsp_t wb_rsp
);

	logic start;
	logic done;
	logic [`LSF_SCRATCH_AW-1:0] lsf_base;

	// Engine side of the RAM ports
	logic [`LSF_SCRATCH_AW-1:0] eng_scratch_rd_addr;
	logic [`LSF_SCRATCH_AW-1:0] eng_scratch_wr_addr;
	lsf_pkg::scratch_word_t eng_scratch_wr_data;
	logic eng_scratch_wr_en;
	logic [`LSF_CONST_AW-1:0] eng_const_rd_addr;

	// RAM side
	logic [`LSF_SCRATCH_AW-1:0] scratch_rd_addr;
	logic [`LSF_SCRATCH_AW-1:0] scratch_wr_addr;
	lsf_pkg::scratch_word_t scratch_wr_data;
	logic scratch_wr_en;
	lsf_pkg::scratch_word_t scratch_rd_data;
	logic [`LSF_CONST_AW-1:0] const_rd_addr;
	logic [`LSF_CONST_AW-1:0] const_wr_addr;
	lsf_pkg::const_word_t const_wr_data;
	logic const_wr_en;
	lsf_pkg::const_word_t const_rd_data;

	// Operator units
	lsf_pkg::op_kind_t op_sel;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] op_result;
	logic shift_start;
	logic [31:0] shift_value;
	logic [4:0] shift_count;
	logic [31:0] shift_result;
	logic shift_done;

	lsf_host_port host_port_i (
		.clock(clock),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.start(start),
		.lsf_base(lsf_base),
		.done(done),
		.eng_scratch_rd_addr(eng_scratch_rd_addr),
		.eng_scratch_wr_addr(eng_scratch_wr_addr),
		.eng_scratch_wr_data(eng_scratch_wr_data),
		.eng_scratch_wr_en(eng_scratch_wr_en),
		.eng_const_rd_addr(eng_const_rd_addr),
		.scratch_rd_addr(scratch_rd_addr),
		.scratch_wr_addr(scratch_wr_addr),
		.scratch_wr_data(scratch_wr_data),
		.scratch_wr_en(scratch_wr_en),
		.scratch_rd_data(scratch_rd_data),
		.const_rd_addr(const_rd_addr),
		.const_wr_addr(const_wr_addr),
		.const_wr_data(const_wr_data),
		.const_wr_en(const_wr_en),
		.const_rd_data(const_rd_data)
	);

	lsp_lsf lsp_lsf_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.done(done),
		.lsf_base(lsf_base),
		.scratch_rd_addr(eng_scratch_rd_addr),
		.scratch_wr_addr(eng_scratch_wr_addr),
		.scratch_wr_data(eng_scratch_wr_data),
		.scratch_wr_en(eng_scratch_wr_en),
		.scratch_rd_data(scratch_rd_data),
		.const_rd_addr(eng_const_rd_addr),
		.const_rd_data(const_rd_data),
		.op_sel(op_sel),
		.op_a(op_a),
		.op_b(op_b),
		.op_result(op_result),
		.shift_start(shift_start),
		.shift_value(shift_value),
		.shift_count(shift_count),
		.shift_result(shift_result),
		.shift_done(shift_done)
	);

	basic_op_unit op_unit_i (
		.op_sel(op_sel),
		.op_a(op_a),
		.op_b(op_b),
		.result(op_result)
	);

	l_shl_unit shifter_i (
		.clock(clock),
		.reset(reset),
		.start(shift_start),
		.value(shift_value),
		.count(shift_count),
		.result(shift_result),
		.done(shift_done)
	);

	lsf_ram #(
		.word_t(lsf_pkg::scratch_word_t),
		.depth(2048)
	) scratch_ram_i (
		.clock(clock),
		.rd_addr(scratch_rd_addr),
		.wr_addr(scratch_wr_addr),
		.wr_en(scratch_wr_en),
		.wr_data(scratch_wr_data),
		.rd_data(scratch_rd_data)
	);

	lsf_ram #(
		.word_t(lsf_pkg::const_word_t),
		.depth(4096)
	) const_ram_i (
		.clock(clock),
		.rd_addr(const_rd_addr),
		.wr_addr(const_wr_addr),
		.wr_en(const_wr_en),
		.wr_data(const_wr_data),
		.rd_data(const_rd_data)
	);

endmodule

// ==== lsp_lsf/lsp_lsf.sv ====
`timescale 1ns/1ps
`include "lsf_defs.svh"

module lsp_lsf (
	input logic clock,
	input logic reset,
	input logic start,
	output logic done,
	input logic [`LSF_SCRATCH_AW-1:0] lsf_base,
	output logic [`LSF_SCRATCH_AW-1:0] scratch_rd_addr,
	output logic [`LSF_SCRATCH_AW-1:0] scratch_wr_addr,
	output lsf_pkg::scratch_word_t scratch_wr_data,
	output logic scratch_wr_en,
	input lsf_pkg::scratch_word_t scratch_rd_data,
	output logic [`LSF_CONST_AW-1:0] const_rd_addr,
	input lsf_pkg::const_word_t const_rd_data,
	output lsf_pkg::op_kind_t op_sel,
	output logic [31:0] op_a,
	output logic [31:0] op_b,
	input logic [31:0] op_result,
	output logic shift_start,
	output logic [31:0] shift_value,
	output logic [4:0] shift_count,
	input logic [31:0] shift_result,
	input logic shift_done
);

	localparam logic [`LSF_CONST_AW-1:0] table_base = `LSF_TABLE_BASE;
	localparam logic [`LSF_CONST_AW-1:0] slope_base = `LSF_SLOPE_BASE;
	localparam logic [`LSF_SCRATCH_AW-1:0] lsp_base = `LSF_LSP_BASE;
	localparam logic [3:0] last_coef = 4'(`LSF_ORDER - 1);

	typedef enum logic [3:0] {
		s_idle,
		s_fetch,
		s_cmp,
		s_dec,
		s_diff,
		s_mult,
		s_shift,
		s_index,
		s_write,
		s_next
	} state_t;

	state_t state, state_n;
	logic [5:0] ind, ind_n;
	logic [3:0] cnt, cnt_n;
	logic [31:0] tmp, tmp_n;

	logic [`LSF_CONST_AW-1:0] table_addr;
	logic [`LSF_CONST_AW-1:0] slope_addr;
	logic [`LSF_SCRATCH_AW-1:0] lsp_addr;
	logic [`LSF_SCRATCH_AW-1:0] out_addr;

	// Aligned bases let the index be concatenated in
	assign table_addr = {table_base[`LSF_CONST_AW-1:6], ind};
	assign slope_addr = {slope_base[`LSF_CONST_AW-1:6], ind};
	assign lsp_addr = {lsp_base[`LSF_SCRATCH_AW-1:4], cnt};
	assign out_addr = {lsf_base[`LSF_SCRATCH_AW-1:4], cnt};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= s_idle;
			ind <= 6'd63;
			cnt <= last_coef;
		end else begin
			state <= state_n;
			ind <= ind_n;
			cnt <= cnt_n;
		end
	end

	always_ff @(posedge clock) begin
		tmp <= tmp_n;
	end

	always_comb begin
		state_n = state;
		ind_n = ind;
		cnt_n = cnt;
		tmp_n = tmp;
		done = 1'b0;
		scratch_rd_addr = lsp_addr;
		scratch_wr_addr = out_addr;
		scratch_wr_data = '0;
		scratch_wr_en = 1'b0;
		const_rd_addr = table_addr;
		op_sel = lsf_pkg::op_add;
		op_a = '0;
		op_b = '0;
		shift_start = 1'b0;
		shift_value = '0;
		shift_count = 5'd0;

		case (state)
			s_idle: begin
				if (start)
					state_n = s_fetch;
			end
			// Table entry and input coefficient read together
			s_fetch: begin
				state_n = s_cmp;
			end
			// Search stops once table[ind] - lsp[i] is non-negative
			s_cmp: begin
				op_sel = lsf_pkg::op_sub;
				op_a = 32'(const_rd_data);
				op_b = {16'd0, scratch_rd_data[15:0]};
				if (!op_result[15]) begin
					tmp_n = scratch_rd_data;
					state_n = s_diff;
				end else begin
					state_n = s_dec;
				end
			end
			s_dec: begin
				op_sel = lsf_pkg::op_sub;
				op_a = {26'd0, ind};
				op_b = 32'd1;
				ind_n = op_result[5:0];
				state_n = s_fetch;
			end
			// Table entry still on the read port, slope requested
			s_diff: begin
				op_sel = lsf_pkg::op_sub;
				op_a = {16'd0, tmp[15:0]};
				op_b = 32'(const_rd_data);
				tmp_n = op_result;
				const_rd_addr = slope_addr;
				state_n = s_mult;
			end
			s_mult: begin
				op_sel = lsf_pkg::op_l_mult;
				op_a = {16'd0, tmp[15:0]};
				op_b = 32'(const_rd_data);
				shift_start = 1'b1;
				shift_value = op_result;
				shift_count = 5'd3;
				state_n = s_shift;
			end
			// Round into the high half
			s_shift: begin
				if (shift_done) begin
					op_sel = lsf_pkg::op_l_add;
					op_a = shift_result;
					op_b = 32'h0000_8000;
					tmp_n = op_result;
					state_n = s_index;
				end
			end
			// Low half now free for ind << 8
			s_index: begin
				op_sel = lsf_pkg::op_shl;
				op_a = {26'd0, ind};
				op_b = 32'd8;
				tmp_n = {tmp[31:16], op_result[15:0]};
				state_n = s_write;
			end
			s_write: begin
				op_sel = lsf_pkg::op_add;
				op_a = {16'd0, tmp[31:16]};
				op_b = {16'd0, tmp[15:0]};
				scratch_wr_data = {16'd0, op_result[15:0]};
				scratch_wr_en = 1'b1;
				state_n = s_next;
			end
			s_next: begin
				if (cnt == 4'd0) begin
					done = 1'b1;
					ind_n = 6'd63;
					cnt_n = last_coef;
					state_n = s_idle;
				end else begin
					// Index carries over, inputs run downward
					op_sel = lsf_pkg::op_sub;
					op_a = {28'd0, cnt};
					op_b = 32'd1;
					cnt_n = op_result[3:0];
					state_n = s_fetch;
				end
			end
			default: begin
				state_n = s_idle;
			end
		endcase
	end

endmodule

// ==== source/lsf_host_port.sv ====
`timescale 1ns/1ps
`include "lsf_defs.svh"

module lsf_host_port (
	input logic clock,
	input logic reset,
	input lsf_pkg::wb_req_t wb_req,
	output lsf_pkg::wb_rsp_t wb_rsp,
	output logic start,
	output logic [`LSF_SCRATCH_AW-1:0] lsf_base,
	input logic done,
	// Engine side
	input logic [`LSF_SCRATCH_AW-1:0] eng_scratch_rd_addr,
	input logic [`LSF_SCRATCH_AW-1:0] eng_scratch_wr_addr,
	input lsf_pkg::scratch_word_t eng_scratch_wr_data,
	input logic eng_scratch_wr_en,
	input logic [`LSF_CONST_AW-1:0] eng_const_rd_addr,
	// Memory side
	output logic [`LSF_SCRATCH_AW-1:0] scratch_rd_addr,
	output logic [`LSF_SCRATCH_AW-1:0] scratch_wr_addr,
	output lsf_pkg::scratch_word_t scratch_wr_data,
	output logic scratch_wr_en,
	input lsf_pkg::scratch_word_t scratch_rd_data,
	output logic [`LSF_CONST_AW-1:0] const_rd_addr,
	output logic [`LSF_CONST_AW-1:0] const_wr_addr,
	output lsf_pkg::const_word_t const_wr_data,
	output logic const_wr_en,
	input lsf_pkg::const_word_t const_rd_data
);

	logic busy;
	logic done_flag;
	logic ack_q;
	logic [1:0] rgn_q;
	logic [31:0] reg_dat_q;
	logic [1:0] rgn;
	logic is_mem;
	logic accept;
	logic ctrl_wr;

	//////////////////////////////////////////////////////////////////////
	// Decode and handshake
	//////////////////////////////////////////////////////////////////////

	assign rgn = wb_req.adr[`LSF_WB_AW-1 -: 2];
	assign is_mem = (rgn == `LSF_RGN_SCRATCH) || (rgn == `LSF_RGN_CONST);

	// Memory held off while the engine owns the RAMs
	assign accept = wb_req.cyc && wb_req.stb && !ack_q && !(is_mem && busy);
	assign ctrl_wr = accept && wb_req.we && (rgn == `LSF_RGN_REGS) && !wb_req.adr[0];

	always_ff @(posedge clock) begin
		if (reset) begin
			ack_q <= 1'b0;
			busy <= 1'b0;
			done_flag <= 1'b0;
			start <= 1'b0;
			lsf_base <= '0;
		end else begin
			ack_q <= accept;
			start <= 1'b0;
			if (ctrl_wr) begin
				done_flag <= 1'b0;
				if (wb_req.dat[0] && !busy) begin
					start <= 1'b1;
					busy <= 1'b1;
					lsf_base <= wb_req.dat[26:16];
				end
			end
			// Engine completion wins over a same-cycle clear
			if (done) begin
				busy <= 1'b0;
				done_flag <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rgn_q <= rgn;
			if (rgn != `LSF_RGN_REGS)
				reg_dat_q <= '0;
			else if (wb_req.adr[0])
				reg_dat_q <= {30'd0, done_flag, busy};
			else
				reg_dat_q <= {5'd0, lsf_base, 16'd0};
		end
	end

	always_comb begin
		wb_rsp.ack = ack_q;
		case (rgn_q)
			`LSF_RGN_SCRATCH: wb_rsp.dat = scratch_rd_data;
			`LSF_RGN_CONST: wb_rsp.dat = {16'd0, const_rd_data};
			default: wb_rsp.dat = reg_dat_q;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// RAM port ownership
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		const_wr_addr = wb_req.adr[`LSF_CONST_AW-1:0];
		const_wr_data = wb_req.dat[15:0];
		const_wr_en = accept && wb_req.we && (rgn == `LSF_RGN_CONST);
		if (busy) begin
			scratch_rd_addr = eng_scratch_rd_addr;
			scratch_wr_addr = eng_scratch_wr_addr;
			scratch_wr_data = eng_scratch_wr_data;
			scratch_wr_en = eng_scratch_wr_en;
			const_rd_addr = eng_const_rd_addr;
		end else begin
			scratch_rd_addr = wb_req.adr[`LSF_SCRATCH_AW-1:0];
			scratch_wr_addr = wb_req.adr[`LSF_SCRATCH_AW-1:0];
			scratch_wr_data = wb_req.dat;
			scratch_wr_en = accept && wb_req.we && (rgn == `LSF_RGN_SCRATCH);
			const_rd_addr = wb_req.adr[`LSF_CONST_AW-1:0];
		end
	end

endmodule

// ==== source/lsf_ram.sv ====
`timescale 1ns/1ps

module lsf_ram #(
	parameter type word_t = logic [31:0],
	parameter int depth = 2048
) (
	input logic clock,
	input logic [$clog2(depth)-1:0] rd_addr,
	input logic [$clog2(depth)-1:0] wr_addr,
	input logic wr_en,
	input word_t wr_data,
	output word_t rd_data
);

	word_t mem [depth];

	// Read returns the old word on a same-address write
	always_ff @(posedge clock) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== source/l_shl_unit.sv ====
`timescale 1ns/1ps

module l_shl_unit (
	input logic clock,
	input logic reset,
	input logic start,
	input logic [31:0] value,
	input logic [4:0] count,
	output logic [31:0] result,
	output logic done
);

	logic [31:0] acc;
	logic [4:0] remain;
	logic active;

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			done <= 1'b0;
			remain <= 5'd0;
		end else if (start) begin
			active <= 1'b1;
			done <= 1'b0;
			remain <= count;
		end else if (active) begin
			if (remain == 5'd0) begin
				active <= 1'b0;
				done <= 1'b1;
			end else begin
				remain <= remain - 5'd1;
			end
		end
	end

	// One bit per cycle, pinned at the sign extreme once it overflows
	always_ff @(posedge clock) begin
		if (start)
			acc <= value;
		else if (active && remain != 5'd0) begin
			if (acc[31] != acc[30])
				acc <= acc[31] ? 32'h8000_0000 : 32'h7fff_ffff;
			else
				acc <= {acc[30:0], 1'b0};
		end
	end

	assign result = acc;

endmodule

// ==== source/basic_op_unit.sv ====
`timescale 1ns/1ps

module basic_op_unit (
	input lsf_pkg::op_kind_t op_sel,
	input logic [31:0] op_a,
	input logic [31:0] op_b,
	output logic [31:0] result
);

	logic signed [15:0] a_16;
	logic signed [15:0] b_16;
	logic signed [16:0] sum_16;
	logic signed [16:0] diff_16;
	logic signed [31:0] shl_wide;
	logic signed [15:0] shl_16;
	logic signed [32:0] sum_32;
	logic signed [31:0] prod;

	// Clamp a 17-bit result into Q15 range
	function automatic logic [15:0] sat_16(input logic signed [16:0] v);
		if (v > 17'sd32767)
			return 16'h7fff;
		else if (v < -17'sd32768)
			return 16'h8000;
		else
			return v[15:0];
	endfunction

	assign a_16 = op_a[15:0];
	assign b_16 = op_b[15:0];
	assign sum_16 = a_16 + b_16;
	assign diff_16 = a_16 - b_16;
	assign shl_wide = 32'(a_16) <<< op_b[3:0];
	assign sum_32 = $signed(op_a) + $signed(op_b);
	assign prod = a_16 * b_16;

	// Negative count shifts right
	always_comb begin
		if (b_16 < -16'sd15)
			shl_16 = {16{a_16[15]}};
		else if (b_16 < 16'sd0)
			shl_16 = a_16 >>> (-b_16);
		else if (b_16 > 16'sd15)
			shl_16 = (a_16 == 16'sd0) ? 16'sd0 : (a_16[15] ? 16'sh8000 : 16'sh7fff);
		else if (shl_wide > 32'sd32767)
			shl_16 = 16'sh7fff;
		else if (shl_wide < -32'sd32768)
			shl_16 = 16'sh8000;
		else
			shl_16 = shl_wide[15:0];
	end

	always_comb begin
		case (op_sel)
			lsf_pkg::op_add: result = 32'($signed(sat_16(sum_16)));
			lsf_pkg::op_sub: result = 32'($signed(sat_16(diff_16)));
			lsf_pkg::op_shl: result = 32'(shl_16);
			lsf_pkg::op_l_add: begin
				if (sum_32[32] != sum_32[31])
					result = sum_32[32] ? 32'h8000_0000 : 32'h7fff_ffff;
				else
					result = sum_32[31:0];
			end
			// Only -1 * -1 overflows after doubling
			lsf_pkg::op_l_mult: begin
				if (prod == 32'sh4000_0000)
					result = 32'h7fff_ffff;
				else
					result = prod <<< 1;
			end
			default: result = '0;
		endcase
	end

endmodule

// ==== common/lsf_pkg.sv ====
`include "lsf_defs.svh"

package lsf_pkg;

	//////////////////////////////////////////////////////////////////////
	// Wishbone classic bus
	//////////////////////////////////////////////////////////////////////

	// Host to port, held stable until ack
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`LSF_WB_AW-1:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	// Port to host, dat valid with ack
	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	//////////////////////////////////////////////////////////////////////
	// Memory words and operator codes
	//////////////////////////////////////////////////////////////////////

	typedef logic [31:0] scratch_word_t;

	// Q15 table entry
	typedef logic signed [15:0] const_word_t;

	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_shl,
		op_l_add,
		op_l_mult
	} op_kind_t;

endpackage

// ==== common/lsf_defs.svh ====
`ifndef LSF_DEFS_SVH
`define LSF_DEFS_SVH

// Memory address widths
`define LSF_SCRATCH_AW 11
`define LSF_CONST_AW 12

// Host word address width, region in the top two bits
`define LSF_WB_AW 14

// Cosine and slope tables in constant memory, 64-entry aligned
`define LSF_TABLE_BASE 12'h040
`define LSF_SLOPE_BASE 12'h080

// Input coefficients in scratch memory, 16-entry aligned
`define LSF_LSP_BASE 11'h010

// Filter order
`define LSF_ORDER 10

// Host regions
`define LSF_RGN_SCRATCH 2'd0
`define LSF_RGN_CONST 2'd1
`define LSF_RGN_REGS 2'd2

`endif
